/* Makefile */
VERILATOR ?= verilator
TOP       ?= branchUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Test FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "Test FAILED"; exit 1; fi
	@echo "Test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/bpPkg.sv */
`default_nettype none

package bpPkg;

    // Predictor geometry
    localparam int bhtIndexBits = 10;  // 1024 local histories
    localparam int historyBits = 6;    // History width, also log2 of pattern table depth
    localparam int pcIndexLsb = 2;     // Word aligned pc, so index starts at bit 2

    // Two-bit saturating counter, high bit is the prediction
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b11,
        strongTaken    = 2'b10
    } counterT;

    // MIPS32 opcodes of the supported conditional branches
    localparam logic [5:0] opRegimm = 6'b000001;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;

    // REGIMM rt field codes
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;

    typedef enum logic [2:0] {
        kindBeq,
        kindBne,
        kindBlez,
        kindBgtz,
        kindBltz,
        kindBgez
    } branchKindT;

endpackage

`default_nettype wire

/* logic/branchDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module branchDecode (
    input  logic               [31:0] instrD,
    input  logic               [31:0] pcD,
    output logic                      isBranch,
    output bpPkg::branchKindT         kind,
    output logic               [31:0] target,
    output logic               [31:0] fallThrough
);

    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [31:0] offsetExt;

    assign opcode = instrD[31:26];
    assign rt     = instrD[20:16];

    // Word offset, sign extended and scaled to bytes
    assign offsetExt = {{14{instrD[15]}}, instrD[15:0], 2'b00};

    always_comb begin
        isBranch = 1'b0;
        kind     = bpPkg::kindBeq;  // Don't care when not a branch
        case (opcode)
            bpPkg::opBeq: begin
                isBranch = 1'b1;
                kind     = bpPkg::kindBeq;
            end
            bpPkg::opBne: begin
                isBranch = 1'b1;
                kind     = bpPkg::kindBne;
            end
            bpPkg::opBlez: begin
                isBranch = 1'b1;
                kind     = bpPkg::kindBlez;
            end
            bpPkg::opBgtz: begin
                isBranch = 1'b1;
                kind     = bpPkg::kindBgtz;
            end
            bpPkg::opRegimm: begin
                // Only bltz and bgez, link forms and traps fall through
                if (rt == bpPkg::rtBltz) begin
                    isBranch = 1'b1;
                    kind     = bpPkg::kindBltz;
                end else if (rt == bpPkg::rtBgez) begin
                    isBranch = 1'b1;
                    kind     = bpPkg::kindBgez;
                end
            end
            default: ;
        endcase
    end

    // Target is relative to the delay slot address
    assign target      = pcD + 32'd4 + offsetExt;
    assign fallThrough = pcD + 32'd8;  // Skip the delay slot

endmodule

`default_nettype wire

/* logic/branchResolve.sv */
`timescale 1ns/100ps
`default_nettype none

module branchResolve (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      validE,
    input  bpPkg::branchKindT         kindE,
    input  logic               [31:0] pcE,
    input  logic               [31:0] targetE,
    input  logic               [31:0] fallThroughE,
    input  logic                      predTakeE,
    input  logic               [31:0] rsValE,
    input  logic               [31:0] rtValE,
    output logic                      branchM,
    output logic                      takenM,
    output logic               [31:0] pcM,
    output logic                      mispredictM,
    output logic               [31:0] redirectPcM
);

    logic rsEqRt;
    logic rsNeg;
    logic rsZero;
    logic takenE;
    logic advance;

    assign rsEqRt = (rsValE == rtValE);
    assign rsNeg  = rsValE[31];          // Two's complement sign
    assign rsZero = (rsValE == 32'd0);

    always_comb begin
        case (kindE)
            bpPkg::kindBeq:  takenE = rsEqRt;
            bpPkg::kindBne:  takenE = !rsEqRt;
            bpPkg::kindBlez: takenE = rsNeg | rsZero;
            bpPkg::kindBgtz: takenE = !rsNeg & !rsZero;
            bpPkg::kindBltz: takenE = rsNeg;
            bpPkg::kindBgez: takenE = !rsNeg;
            default:         takenE = 1'b0;
        endcase
    end

    // A mispredict in memory kills the entry now in execute as well
    assign advance = validE & !stall & !mispredictM;

    // Memory stage strobes, a bubble whenever nothing advances
    always_ff @(posedge clk) begin
        if (rst) begin
            branchM     <= 1'b0;
            mispredictM <= 1'b0;
        end else begin
            branchM     <= advance;
            mispredictM <= advance & (takenE != predTakeE);
        end
    end

    // Outcome payload for training and redirect
    always_ff @(posedge clk) begin
        if (advance) begin
            takenM      <= takenE;
            pcM         <= pcE;
            redirectPcM <= takenE ? targetE : fallThroughE;
        end
    end

endmodule

`default_nettype wire

/* logic/branchStageReg.sv */
`timescale 1ns/100ps
`default_nettype none

module branchStageReg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      validD,
    input  logic                      isBranch,
    input  bpPkg::branchKindT         kind,
    input  logic               [31:0] pcD,
    input  logic               [31:0] target,
    input  logic               [31:0] fallThrough,
    input  logic                      predTake,
    output logic                      validE,
    output bpPkg::branchKindT         kindE,
    output logic               [31:0] pcE,
    output logic               [31:0] targetE,
    output logic               [31:0] fallThroughE,
    output logic                      predTakeE
);

    // Valid bit, flush beats stall
    always_ff @(posedge clk) begin
        if (rst) begin
            validE <= 1'b0;
        end else if (flush) begin
            validE <= 1'b0;  // Wrong path entry from decode
        end else if (!stall) begin
            validE <= validD & isBranch;
        end
    end

    // Payload only matters while validE is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            kindE        <= kind;
            pcE          <= pcD;
            targetE      <= target;
            fallThroughE <= fallThrough;
            predTakeE    <= predTake;
        end
    end

endmodule

`default_nettype wire

/* logic/branchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  logic        clk,
    input  logic        rst,
    input  logic        validD,
    input  logic        stall,
    input  logic [31:0] instrD,
    input  logic [31:0] pcD,
    input  logic [31:0] rsValE,
    input  logic [31:0] rtValE,
    output logic        isBranchD,
    output logic        predTakeD,
    output logic        branchM,
    output logic        takenM,
    output logic        mispredictM,
    output logic [31:0] redirectPcM
);

    bpPkg::branchKindT kindD;
    logic [31:0]       targetD;
    logic [31:0]       fallThroughD;

    logic              validE;
    bpPkg::branchKindT kindE;
    logic [31:0]       pcE;
    logic [31:0]       targetE;
    logic [31:0]       fallThroughE;
    logic              predTakeE;

    logic [31:0]       pcM;  // Training address, internal only

    branchDecode decode (
        .instrD      (instrD),
        .pcD         (pcD),
        .isBranch    (isBranchD),
        .kind        (kindD),
        .target      (targetD),
        .fallThrough (fallThroughD)
    );

    localPredictor predictor (
        .clk      (clk),
        .rst      (rst),
        .pcD      (pcD),
        .isBranch (isBranchD),
        .predTake (predTakeD),
        .branchM  (branchM),
        .takenM   (takenM),
        .pcM      (pcM)
    );

    branchStageReg stageDE (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (mispredictM),  // Redirect drops the decode entry
        .validD       (validD),
        .isBranch     (isBranchD),
        .kind         (kindD),
        .pcD          (pcD),
        .target       (targetD),
        .fallThrough  (fallThroughD),
        .predTake     (predTakeD),
        .validE       (validE),
        .kindE        (kindE),
        .pcE          (pcE),
        .targetE      (targetE),
        .fallThroughE (fallThroughE),
        .predTakeE    (predTakeE)
    );

    branchResolve resolve (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .validE       (validE),
        .kindE        (kindE),
        .pcE          (pcE),
        .targetE      (targetE),
        .fallThroughE (fallThroughE),
        .predTakeE    (predTakeE),
        .rsValE       (rsValE),
        .rtValE       (rtValE),
        .branchM      (branchM),
        .takenM       (takenM),
        .pcM          (pcM),
        .mispredictM  (mispredictM),
        .redirectPcM  (redirectPcM)
    );

endmodule

`default_nettype wire

/* logic/localPredictor.sv */
`timescale 1ns/100ps
`default_nettype none

module localPredictor (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pcD,
    input  logic        isBranch,
    output logic        predTake,
    input  logic        branchM,
    input  logic        takenM,
    input  logic [31:0] pcM
);

    // First level: per-branch local history
    logic [bpPkg::historyBits-1:0] bht [(1 << bpPkg::bhtIndexBits)];

    // Second level: counters shared by all branches, indexed by history
    bpPkg::counterT pht [(1 << bpPkg::historyBits)];

    logic [bpPkg::bhtIndexBits-1:0] readIdx;
    logic [bpPkg::historyBits-1:0]  readHist;
    logic [1:0]                     readCnt;

    logic [bpPkg::bhtIndexBits-1:0] updIdx;
    logic [bpPkg::historyBits-1:0]  updHist;
    bpPkg::counterT                 updCnt;
    bpPkg::counterT                 nextCnt;

    // Decode side lookup
    assign readIdx  = pcD[bpPkg::pcIndexLsb +: bpPkg::bhtIndexBits];
    assign readHist = bht[readIdx];
    assign readCnt  = pht[readHist];

    assign predTake = isBranch & readCnt[1];  // High bit means taken

    // Memory side lookup for training
    assign updIdx  = pcM[bpPkg::pcIndexLsb +: bpPkg::bhtIndexBits];
    assign updHist = bht[updIdx];  // Old history selects the counter
    assign updCnt  = pht[updHist];

    // Saturating step toward the real outcome
    always_comb begin
        case (updCnt)
            bpPkg::strongNotTaken: begin
                nextCnt = takenM ? bpPkg::weakNotTaken : bpPkg::strongNotTaken;
            end
            bpPkg::weakNotTaken: begin
                nextCnt = takenM ? bpPkg::weakTaken : bpPkg::strongNotTaken;
            end
            bpPkg::weakTaken: begin
                nextCnt = takenM ? bpPkg::strongTaken : bpPkg::weakNotTaken;
            end
            bpPkg::strongTaken: begin
                nextCnt = takenM ? bpPkg::strongTaken : bpPkg::weakTaken;
            end
            default: begin
                nextCnt = bpPkg::weakTaken;
            end
        endcase
    end

    // History shift, newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << bpPkg::bhtIndexBits); i++) begin
                bht[i] <= '0;
            end
        end else if (branchM) begin
            bht[updIdx] <= {updHist[bpPkg::historyBits-2:0], takenM};
        end
    end

    // Counter update, only when a branch resolves
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << bpPkg::historyBits); i++) begin
                pht[i] <= bpPkg::weakTaken;  // Start slightly biased to taken
            end
        end else if (branchM) begin
            pht[updHist] <= nextCnt;
        end
    end

endmodule

`default_nettype wire

/* tests/branchUnitTb.sv */
`timescale 1ns/100ps
`default_nettype none

module branchUnitTb;

    logic        clk;
    logic        rst = 1'b1;
    logic        validD;
    logic        stall;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic [31:0] rsValE;
    logic [31:0] rtValE;
    logic        isBranchD;
    logic        predTakeD;
    logic        branchM;
    logic        takenM;
    logic        mispredictM;
    logic [31:0] redirectPcM;

    integer seedVar = 32'hadbb_3a21;

    // Model tables with counter levels from 0 strong not taken to 3 strong taken
    logic [bpPkg::historyBits-1:0] refBht [1 << bpPkg::bhtIndexBits];
    int                            refLevel [1 << bpPkg::historyBits];

    // Model pipeline with execute and memory slots
    logic              exeValid;
    logic              exePred;
    bpPkg::branchKindT exeKind;
    logic [31:0]       exePc;
    logic [31:0]       exeTarget;
    logic [31:0]       exeFall;
    logic              memValid;
    logic              memMis;
    logic              memTaken;
    logic [31:0]       memPc;

    // Expected decode outputs for the instruction now in decode
    logic              expIsBr;
    logic              expPred;
    bpPkg::branchKindT expKind;

    // Outcomes in issue order
    logic        expTaken [$];
    logic        expMis [$];
    logic [31:0] expRedirect [$];
    int          misToTaken;
    int          misToNot;

    branchUnit UUT (
        .clk         (clk),
        .rst         (rst),
        .validD      (validD),
        .stall       (stall),
        .instrD      (instrD),
        .pcD         (pcD),
        .rsValE      (rsValE),
        .rtValE      (rtValE),
        .isBranchD   (isBranchD),
        .predTakeD   (predTakeD),
        .branchM     (branchM),
        .takenM      (takenM),
        .mispredictM (mispredictM),
        .redirectPcM (redirectPcM)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkAddr(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %08h got %08h", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkKind(input string name, input bpPkg::branchKindT act,
                             input bpPkg::branchKindT exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    function automatic logic [31:0] pickInstr(input logic [3:0] sel, input logic [15:0] off);
        case (sel)
            4'd0: return {bpPkg::opBeq, 5'd1, 5'd2, off};
            4'd1: return {bpPkg::opBne, 5'd1, 5'd2, off};
            4'd2: return {bpPkg::opBlez, 5'd1, 5'd0, off};
            4'd3: return {bpPkg::opBgtz, 5'd1, 5'd0, off};
            4'd4: return {bpPkg::opRegimm, 5'd1, bpPkg::rtBltz, off};
            4'd5: return {bpPkg::opRegimm, 5'd1, bpPkg::rtBgez, off};
            4'd6: return {6'h23, 5'd1, 5'd2, off};      // lw
            4'd7: return {bpPkg::opRegimm, 5'd1, 5'h10, off};  // bltzal is not supported
            4'd8: return {6'h00, 5'd1, 5'd2, off};      // SPECIAL
            default: return {6'h02, 10'd0, off};        // j
        endcase
    endfunction

    function automatic logic decodeRef(input logic [31:0] instr, output bpPkg::branchKindT kind);
        decodeRef = 1'b1;
        kind = bpPkg::kindBeq;
        if (instr[31:26] == bpPkg::opBeq) kind = bpPkg::kindBeq;
        else if (instr[31:26] == bpPkg::opBne) kind = bpPkg::kindBne;
        else if (instr[31:26] == bpPkg::opBlez) kind = bpPkg::kindBlez;
        else if (instr[31:26] == bpPkg::opBgtz) kind = bpPkg::kindBgtz;
        else if (instr[31:26] == bpPkg::opRegimm && instr[20:16] == bpPkg::rtBltz)
            kind = bpPkg::kindBltz;
        else if (instr[31:26] == bpPkg::opRegimm && instr[20:16] == bpPkg::rtBgez)
            kind = bpPkg::kindBgez;
        else decodeRef = 1'b0;
    endfunction

    function automatic logic refPredict(input logic [31:0] pc, input logic isBr);
        logic [bpPkg::historyBits-1:0] hist;
        hist = refBht[pc[bpPkg::pcIndexLsb +: bpPkg::bhtIndexBits]];
        return isBr && (refLevel[hist] >= 2);
    endfunction

    function automatic logic outcomeRef(input bpPkg::branchKindT kind, input logic [31:0] rs,
                                        input logic [31:0] rt);
        case (kind)
            bpPkg::kindBeq:  return rs == rt;
            bpPkg::kindBne:  return rs != rt;
            bpPkg::kindBlez: return $signed(rs) <= 0;
            bpPkg::kindBgtz: return $signed(rs) > 0;
            bpPkg::kindBltz: return $signed(rs) < 0;
            default:         return $signed(rs) >= 0;
        endcase
    endfunction

    task automatic trainRef(input logic [31:0] pc, input logic taken);
        logic [bpPkg::bhtIndexBits-1:0] idx;
        logic [bpPkg::historyBits-1:0]  hist;
        idx = pc[bpPkg::pcIndexLsb +: bpPkg::bhtIndexBits];
        hist = refBht[idx];
        if (taken && refLevel[hist] < 3) refLevel[hist]++;
        if (!taken && refLevel[hist] > 0) refLevel[hist]--;
        refBht[idx] = {hist[bpPkg::historyBits-2:0], taken};
    endtask

    // One rising edge of the model using the inputs held during the last cycle
    task automatic modelEdge();
        logic mis;
        logic taken;
        mis = memValid && memMis;
        if (memValid) trainRef(memPc, memTaken);
        memValid = exeValid && !stall && !mis;
        if (memValid) begin
            taken = outcomeRef(exeKind, rsValE, rtValE);
            memTaken = taken;
            memPc = exePc;
            memMis = (taken != exePred);
            if (memMis && taken) misToTaken++;
            if (memMis && !taken) misToNot++;
            expTaken.push_back(taken);
            expMis.push_back(memMis);
            expRedirect.push_back(taken ? exeTarget : exeFall);
        end
        if (mis) begin
            exeValid = 1'b0;  // Wrong path entry dropped
        end else if (!stall) begin
            exeValid = validD && expIsBr;
            exeKind = expKind;
            exePc = pcD;
            exeTarget = pcD + 32'd4 + ({{16{instrD[15]}}, instrD[15:0]} << 2);
            exeFall = pcD + 32'd8;
            exePred = expPred;
        end
    endtask

    task automatic cycleStep(input logic v, input logic s, input logic [31:0] instr,
                             input logic [31:0] pc, input logic [31:0] rs, input logic [31:0] rt);
        @(posedge clk);
        #1;
        modelEdge();
        validD = v;
        stall = s;
        instrD = instr;
        pcD = pc;
        rsValE = rs;
        rtValE = rt;
        expIsBr = decodeRef(instr, expKind);
        expPred = refPredict(pc, expIsBr);
        #1;
        checkBit("isBranchD", isBranchD, expIsBr);
        checkBit("predTakeD", predTakeD, expPred);
        if (expIsBr) checkKind("kindD", UUT.kindD, expKind);
    endtask

    // Outcome comparison at every memory stage pulse
    initial begin
        int waitCycles;
        waitCycles = 0;
        while (rst) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > 20) begin
                $display("Reset was never released");
                abortRun();
            end
        end
        waitCycles = 0;
        forever begin
            @(posedge clk);
            #3;
            if (branchM) begin
                if (expTaken.size() == 0) begin
                    $display("branchM pulsed at %0t with no branch left to resolve", $time);
                    abortRun();
                end
                checkBit("takenM", takenM, expTaken.pop_front());
                checkBit("mispredictM", mispredictM, expMis.pop_front());
                checkAddr("redirectPcM", redirectPcM, expRedirect.pop_front());
                waitCycles = 0;
            end else begin
                checkBit("mispredictM", mispredictM, 1'b0);
                if (expTaken.size() != 0) waitCycles++;
                if (waitCycles > 20) begin
                    $display("No branchM within 20 cycles while a branch was pending");
                    abortRun();
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] ops;
        logic [31:0] rs;
        validD = 1'b0;
        stall = 1'b0;
        instrD = '0;
        pcD = '0;
        rsValE = '0;
        rtValE = '0;
        foreach (refBht[i]) refBht[i] = '0;
        foreach (refLevel[i]) refLevel[i] = 2;  // Weakly taken
        exeValid = 1'b0;
        memValid = 1'b0;
        expIsBr = 1'b0;
        expPred = 1'b0;
        expKind = bpPkg::kindBeq;
        misToTaken = 0;
        misToNot = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Decode of every kind and of other encodings with nothing issued
        for (int n = 0; n < 10; n++) begin
            cycleStep(1'b0, 1'b0, pickInstr(n[3:0], 16'h0010), 32'h0040_0000 + n * 4, '0, '0);
            if (n == 0) checkBit("predTakeD", predTakeD, 1'b1);  // Fresh counters lean taken
        end

        // Two passes of a loop branch taken nine times before one exit
        for (int n = 0; n < 20; n++) begin
            cycleStep(1'b1, 1'b0, pickInstr(4'd1, 16'hfff0), 32'h0040_0200, '0, '0);
            ops = (n % 10 == 9) ? 32'd7 : 32'd3;
            cycleStep(1'b0, 1'b0, '0, 32'h0040_0204, ops, 32'd7);
        end

        // Forced mispredicts with followers that must be flushed
        for (int n = 0; n < 8; n++) begin
            cycleStep(1'b1, 1'b0, pickInstr(4'd0, 16'h0040), 32'h0040_0800, '0, '0);
            ops = expPred ? 32'd1 : 32'd2;
            cycleStep(1'b1, 1'b0, pickInstr(4'd3, 16'h0008), 32'h0040_0804, ops, 32'd2);
            cycleStep(1'b1, 1'b0, pickInstr(4'd5, 16'h0008), 32'h0040_0808, 32'd5, '0);
            cycleStep(1'b0, 1'b0, '0, 32'h0040_080c, '0, '0);
        end

        // Random stream with stalls and aliasing pcs
        for (int n = 0; n < 400; n++) begin
            r = $random(seedVar);
            case (r[9:8])
                2'd0: rs = '0;
                2'd1: rs = 32'd1;
                2'd2: rs = 32'hffff_ffff;
                default: rs = $random(seedVar);
            endcase
            cycleStep(r[27:26] != 2'd0, r[29:28] == 2'd0, pickInstr(r[13:10] % 4'd10, r[31:16]),
                      32'h0040_0000 + {18'd0, r[1:0], 12'd0} + {27'd0, r[4:2], 2'd0},
                      rs, r[5] ? rs : {r[31:17], r[7:6], r[14:0]});
        end

        // Drain every branch still in decode, execute or memory
        for (int n = 0; n < 20 && (expTaken.size() != 0 || memValid || exeValid
                                   || (validD && expIsBr)); n++) begin
            cycleStep(1'b0, 1'b0, '0, '0, '0, '0);
        end
        #2;
        if (expTaken.size() != 0 || misToTaken == 0 || misToNot == 0) begin
            $display("Pending outcomes %0d, mispredicts to taken %0d, to not taken %0d",
                     expTaken.size(), misToTaken, misToNot);
            abortRun();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/branchUnit_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module branchUnitChk (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic isBranchD,
    input logic predTakeD,
    input logic branchM,
    input logic mispredictM
);

    // A redirect only comes from a resolving branch
    assert property (@(posedge clk) disable iff (rst) mispredictM |-> branchM)
        else $error("mispredictM without branchM");

    assert property (@(posedge clk) disable iff (rst) (branchM && stall) |=> !branchM)
        else $error("branchM high two cycles running under stall");

    assert property (@(posedge clk) rst |=> (!branchM && !mispredictM))
        else $error("Strobe high during reset");

    assert property (@(posedge clk) disable iff (rst) predTakeD |-> isBranchD)
        else $error("Prediction without a branch in decode");

endmodule

bind branchUnit branchUnitChk chk (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .isBranchD   (isBranchD),
    .predTakeD   (predTakeD),
    .branchM     (branchM),
    .mispredictM (mispredictM)
);

`default_nettype wire

/* verilog.f */
logic/bpPkg.sv
logic/branchDecode.sv
logic/localPredictor.sv
logic/branchStageReg.sv
logic/branchResolve.sv
logic/branchUnit.sv
tests/branchUnit_chk.sv
tests/branchUnitTb.sv
